/* tb/sink_scan_vectors.txt */
# my_cluster(hex) plant_i plant_j plant decoy exp_found exp_neigh_idx exp_sink_idx
# Indices and flags are decimal. A decoy sits at neighbor plant_i - 1.
0011 40 7 1 0 1 40 7
00a5 5 3 1 0 1 5 3
1234 63 15 1 0 1 63 15
0042 0 0 1 0 1 0 0
beef 22 9 1 1 1 22 9
7001 9 0 1 1 1 9 0
0000 0 0 0 0 0 0 0
ffff 0 0 0 0 0 0 0
3c3c 1 12 1 1 1 1 12
5555 31 4 1 0 1 31 4
0abc 0 0 0 0 0 0 0
2468 50 14 1 1 1 50 14

/* sink_aggregator_top.f */
hw/sink_pkg.sv
hw/node_table_mem.sv
hw/axil_host_port.sv
hw/sink_match_scan.sv
hw/sink_aggregator_top.sv
tb/tb_sink_aggregator.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.
# The script exits with the simulator's status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_sink_aggregator \
    -f sink_aggregator_top.f \
    --Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim \
    || exit $?

/* tb/tb_sink_aggregator.sv */
`timescale 1ns/1ps

module tb_sink_aggregator;

    localparam int  SCAN_CYCLES = 64 * 20 + 4;
    localparam int  AXI_CYCLES  = 200;
    // Table fill and read-back before the first scan.
    localparam int  FILL_CYCLES = 1400;
    localparam real CYCLE_NS    = 4.0;

    typedef struct packed {
        sink_pkg::word_t my_cluster;
        sink_pkg::idx_t  plant_i;
        sink_pkg::sidx_t plant_j;
        logic            plant;
        logic            decoy;
        logic            found;
        sink_pkg::idx_t  neigh_idx;
        sink_pkg::sidx_t sink_idx;
    } scan_vector_t;

    logic clock, rst_n, awvalid, wvalid, bready, arvalid, rready;
    logic [11:0] awaddr, araddr;
    logic [31:0] wdata, rdata;
    logic awready, wready, bvalid, arready, rvalid, done_irq;
    sink_pkg::axil_resp_e bresp, rresp;

    scan_vector_t    vecs[$];
    sink_pkg::word_t table_img [sink_pkg::MEM_WORDS];
    logic [31:0]     lfsr;

    sink_aggregator_top dut_i (.*);

    always #2 clock = ~clock;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    // Inputs change half a nanosecond after the rising edge.
    task automatic step();
        @(posedge clock);
        #0.5;
    endtask

    // A Galois LFSR that steps once for each bit it returns.
    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] val;
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            val  = {val[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [11:0] word_addr(input sink_pkg::waddr_t a);
        return {2'b00, a, 2'b00};
    endfunction

    task automatic check_word(input string name, input sink_pkg::word_t got,
                              input sink_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: time %0t signal %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input sink_pkg::axil_resp_e got,
                              input sink_pkg::axil_resp_e exp);
        if (got !== exp) begin
            abort_run($sformatf("error: time %0t signal %s got %s expected %s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_status(input string name, input sink_pkg::scan_status_t got,
                                input sink_pkg::scan_status_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error: time %0t signal %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    // ----------------------------------------
    // AXI4-Lite master
    // ----------------------------------------

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             output sink_pkg::axil_resp_e resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        step();
        while (!(awready && wready)) step();
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        while (!bvalid) step();
        resp = bresp;
        step();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output sink_pkg::axil_resp_e resp);
        araddr  = addr;
        arvalid = 1'b1;
        step();
        while (!arready) step();
        step();
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) step();
        data = rdata;
        resp = rresp;
        step();
        rready = 1'b0;
    endtask

    task automatic write_expect(input logic [11:0] addr, input logic [31:0] data,
                                input sink_pkg::axil_resp_e exp);
        sink_pkg::axil_resp_e resp;
        axi_write(addr, data, resp);
        check_resp("bresp", resp, exp);
    endtask

    task automatic read_status(output sink_pkg::scan_status_t s);
        logic [31:0] st, m;
        sink_pkg::axil_resp_e resp;
        axi_read(sink_pkg::REG_STATUS, st, resp);
        check_resp("rresp", resp, sink_pkg::OKAY);
        axi_read(sink_pkg::REG_MATCH, m, resp);
        check_resp("rresp", resp, sink_pkg::OKAY);
        s.busy      = st[0];
        s.done      = st[1];
        s.found     = st[2];
        s.neigh_idx = m[5:0];
        s.sink_idx  = m[11:8];
    endtask

    // ----------------------------------------
    // Vectors and tables
    // ----------------------------------------

    task automatic load_vectors();
        int fd, code, cl, pi, pj, pl, dc, fo, ni, si;
        string line;
        scan_vector_t v;
        fd = $fopen("tb/sink_scan_vectors.txt", "r");
        if (fd == 0) abort_run("cannot open the vector file tb/sink_scan_vectors.txt");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%h %d %d %d %d %d %d %d",
                               cl, pi, pj, pl, dc, fo, ni, si);
                if (code != 8) abort_run({"malformed vector line: ", line});
                v.my_cluster = sink_pkg::word_t'(cl);
                v.plant_i    = sink_pkg::idx_t'(pi);
                v.plant_j    = sink_pkg::sidx_t'(pj);
                v.plant      = pl[0];
                v.decoy      = dc[0];
                v.found      = fo[0];
                v.neigh_idx  = sink_pkg::idx_t'(ni);
                v.sink_idx   = sink_pkg::sidx_t'(si);
                vecs.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    // Sinks carry bit 15 and their own index, neighbors never carry bit 15,
    // so a sink shows up in the neighbor table only where it is planted.
    task automatic fill_tables();
        sink_pkg::word_t r;
        sink_pkg::axil_resp_e resp;
        logic [31:0] data;
        int a;
        for (a = 0; a < 164; a++) begin
            r = random_bits(16);
            if (a >= int'(sink_pkg::SINK_BASE) &&
                a < int'(sink_pkg::SINK_BASE) + sink_pkg::NUM_SINKS) begin
                r = {1'b1, r[10:0], sink_pkg::sidx_t'(a - int'(sink_pkg::SINK_BASE))};
            end else if (a >= int'(sink_pkg::NEIGH_BASE) &&
                         a < int'(sink_pkg::CLUSTER_BASE)) begin
                r[15] = 1'b0;
            end
            table_img[a] = r;
            if (a == 0 || a >= int'(sink_pkg::SINK_BASE)) begin
                write_expect(word_addr(sink_pkg::waddr_t'(a)), {16'h0000, r}, sink_pkg::OKAY);
            end
        end
        for (a = 0; a < 164; a++) begin
            if (a == 0 || a >= int'(sink_pkg::SINK_BASE)) begin
                axi_read(word_addr(sink_pkg::waddr_t'(a)), data, resp);
                check_resp("rresp", resp, sink_pkg::OKAY);
                check_word("rdata", data[15:0], table_img[a]);
            end
        end
    endtask

    task automatic run_vector(input scan_vector_t v);
        sink_pkg::waddr_t ni, di;
        sink_pkg::word_t cl, sink_id;
        sink_pkg::scan_status_t got, exp;
        sink_pkg::axil_resp_e resp;
        logic [31:0] data;
        logic lock_test;
        realtime t0;
        ni        = {2'b00, v.plant_i};
        di        = ni - 8'd1;
        sink_id   = table_img[sink_pkg::SINK_BASE + {4'b0000, v.plant_j}];
        lock_test = !v.plant || v.plant_i >= 6'd4;
        write_expect(sink_pkg::REG_CLUSTER, {16'h0000, v.my_cluster}, sink_pkg::OKAY);
        if (v.plant) begin
            cl = random_bits(16);
            if (cl == v.my_cluster) cl = cl ^ 16'h0001;
            write_expect(word_addr(sink_pkg::CLUSTER_BASE + ni), {16'h0000, cl}, sink_pkg::OKAY);
            write_expect(word_addr(sink_pkg::NEIGH_BASE + ni), {16'h0000, sink_id}, sink_pkg::OKAY);
        end
        // The decoy matches earlier but sits in the node's own cluster.
        if (v.decoy) begin
            write_expect(word_addr(sink_pkg::CLUSTER_BASE + di), {16'h0000, v.my_cluster},
                         sink_pkg::OKAY);
            write_expect(word_addr(sink_pkg::NEIGH_BASE + di), {16'h0000, sink_id},
                         sink_pkg::OKAY);
        end
        write_expect(sink_pkg::REG_CTRL, 32'd1, sink_pkg::OKAY);
        t0 = $realtime;
        if (lock_test) begin
            exp = '0;
            exp.busy = 1'b1;
            read_status(got);
            check_status("status", got, exp);
            write_expect(word_addr(8'd0), {16'h0000, ~table_img[0]}, sink_pkg::SLVERR);
            write_expect(sink_pkg::REG_CTRL, 32'd1, sink_pkg::SLVERR);
        end
        while (!done_irq) begin
            if ($realtime - t0 > SCAN_CYCLES * CYCLE_NS) begin
                abort_run("done_irq did not rise within the scan time limit");
            end
            step();
        end
        exp.busy      = 1'b0;
        exp.done      = 1'b1;
        exp.found     = v.found;
        exp.neigh_idx = v.neigh_idx;
        exp.sink_idx  = v.sink_idx;
        read_status(got);
        check_status("status", got, exp);
        if (lock_test) begin
            axi_read(word_addr(8'd0), data, resp);
            check_resp("rresp", resp, sink_pkg::OKAY);
            check_word("rdata", data[15:0], table_img[0]);
        end
        // Put the neighbor table back for the next vector.
        if (v.plant) begin
            write_expect(word_addr(sink_pkg::NEIGH_BASE + ni),
                         {16'h0000, table_img[sink_pkg::NEIGH_BASE + ni]}, sink_pkg::OKAY);
        end
        if (v.decoy) begin
            write_expect(word_addr(sink_pkg::NEIGH_BASE + di),
                         {16'h0000, table_img[sink_pkg::NEIGH_BASE + di]}, sink_pkg::OKAY);
        end
        axi_read(12'h500, data, resp);
        check_resp("rresp", resp, sink_pkg::SLVERR);
        check_word("rdata[31:16]", data[31:16], 16'h0000);
        check_word("rdata[15:0]", data[15:0], 16'h0000);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        real limit;
        logic [31:0] data;
        sink_pkg::axil_resp_e resp;
        clock   = 1'b0;
        rst_n   = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        araddr  = '0;
        wdata   = '0;
        lfsr    = 32'd80629;
        load_vectors();
        limit = (real'(vecs.size()) * (SCAN_CYCLES + AXI_CYCLES) + FILL_CYCLES) * CYCLE_NS;
        fork
            begin
                #(limit);
                abort_run("watchdog expired before all scan vectors finished");
            end
        join_none
        repeat (5) @(posedge clock);
        #0.5;
        rst_n = 1'b1;
        step();
        if (done_irq !== 1'b0) begin
            abort_run($sformatf("error: time %0t signal done_irq got %b expected 0",
                                $time, done_irq));
        end
        axi_read(sink_pkg::REG_STATUS, data, resp);
        check_resp("rresp", resp, sink_pkg::OKAY);
        check_word("rdata[31:16]", data[31:16], 16'h0000);
        check_word("rdata[15:0]", data[15:0], 16'h0000);
        fill_tables();
        foreach (vecs[n]) begin
            run_vector(vecs[n]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* hw/sink_aggregator_top.sv */
`timescale 1ns/1ps

module sink_aggregator_top (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    awvalid,
    input  logic                    wvalid,
    input  logic                    bready,
    input  logic                    arvalid,
    input  logic                    rready,
    input  logic [11:0]             awaddr,
    input  logic [11:0]             araddr,
    input  logic [31:0]             wdata,
    output logic                    awready,
    output logic                    wready,
    output logic                    bvalid,
    output logic                    arready,
    output logic                    rvalid,
    output sink_pkg::axil_resp_e    bresp,
    output sink_pkg::axil_resp_e    rresp,
    output logic [31:0]             rdata,
    output logic                    done_irq
);

    sink_pkg::mem_wr_t      host_wr;
    sink_pkg::mem_rd_t      host_rd;
    sink_pkg::mem_rd_t      scan_rd;
    sink_pkg::word_t        host_rdata;
    sink_pkg::word_t        scan_rdata;
    sink_pkg::scan_ctrl_t   ctrl;
    sink_pkg::scan_status_t status;

    // ----------------------------------------
    // Host side
    // ----------------------------------------

    axil_host_port host_port_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .wvalid    (wvalid),
        .bready    (bready),
        .arvalid   (arvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .araddr    (araddr),
        .wdata     (wdata),
        .awready   (awready),
        .wready    (wready),
        .bvalid    (bvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .bresp     (bresp),
        .rresp     (rresp),
        .rdata     (rdata),
        .mem_wr    (host_wr),
        .mem_rd    (host_rd),
        .mem_rdata (host_rdata),
        .ctrl      (ctrl),
        .status    (status)
    );

    // ----------------------------------------
    // Tables and scanner
    // ----------------------------------------

    node_table_mem table_mem_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .host_wr    (host_wr),
        .host_rd    (host_rd),
        .host_rdata (host_rdata),
        .scan_rd    (scan_rd),
        .scan_rdata (scan_rdata)
    );

    sink_match_scan scan_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .mem_rd    (scan_rd),
        .mem_rdata (scan_rdata),
        .status    (status)
    );

    // The interrupt follows the sticky done flag until the next start.
    assign done_irq = status.done;

endmodule

/* hw/sink_match_scan.sv */
`timescale 1ns/1ps

module sink_match_scan (
    input  logic                    clock,
    input  logic                    rst_n,
    input  sink_pkg::scan_ctrl_t    ctrl,
    output sink_pkg::mem_rd_t       mem_rd,
    input  sink_pkg::word_t         mem_rdata,
    output sink_pkg::scan_status_t  status
);

    sink_pkg::scan_state_e state;
    // The state that issued the read whose data is on mem_rdata now.
    sink_pkg::scan_state_e rd_tag;
    sink_pkg::idx_t  i, rd_i, match_i;
    sink_pkg::sidx_t j, rd_j, match_j;
    sink_pkg::word_t neigh_id, neigh_cluster, my_cluster;
    logic done, found, hit;

    // A sink word is back. It counts only for a neighbor in a foreign cluster.
    assign hit = (rd_tag == sink_pkg::S_SINKS) && (mem_rdata == neigh_id)
                 && (neigh_cluster != my_cluster);

    // ----------------------------------------
    // Read issue
    // ----------------------------------------

    // Reads stop as soon as a hit is seen, and the one in flight is dropped.
    always_comb begin
        mem_rd.en   = 1'b0;
        mem_rd.addr = '0;
        case (state)
            sink_pkg::S_NEIGH: begin
                mem_rd.en   = !hit;
                mem_rd.addr = sink_pkg::NEIGH_BASE + {2'b00, i};
            end
            sink_pkg::S_CLUSTER: begin
                mem_rd.en   = !hit;
                mem_rd.addr = sink_pkg::CLUSTER_BASE + {2'b00, i};
            end
            sink_pkg::S_SINKS: begin
                mem_rd.en   = !hit;
                mem_rd.addr = sink_pkg::SINK_BASE + {4'b0000, j};
            end
            default: begin
                mem_rd.en   = 1'b0;
            end
        endcase
    end

    // ----------------------------------------
    // Scan FSM
    // ----------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= sink_pkg::S_IDLE;
            rd_tag  <= sink_pkg::S_IDLE;
            i       <= '0;
            j       <= '0;
            done    <= 1'b0;
            found   <= 1'b0;
            match_i <= '0;
            match_j <= '0;
        end else begin
            rd_tag <= mem_rd.en ? state : sink_pkg::S_IDLE;
            if (hit) begin
                // The compared sink belongs to the read of the previous cycle.
                state   <= sink_pkg::S_IDLE;
                done    <= 1'b1;
                found   <= 1'b1;
                match_i <= rd_i;
                match_j <= rd_j;
            end else begin
                case (state)
                    sink_pkg::S_IDLE: begin
                        if (ctrl.start) begin
                            state   <= sink_pkg::S_NEIGH;
                            i       <= '0;
                            j       <= '0;
                            done    <= 1'b0;
                            found   <= 1'b0;
                            match_i <= '0;
                            match_j <= '0;
                        end
                    end
                    sink_pkg::S_NEIGH: state <= sink_pkg::S_CLUSTER;
                    sink_pkg::S_CLUSTER: begin
                        state <= sink_pkg::S_SINKS;
                        j     <= '0;
                    end
                    sink_pkg::S_SINKS: begin
                        j <= j + 1'b1;
                        if (j == sink_pkg::sidx_t'(sink_pkg::NUM_SINKS - 1)) begin
                            if (i == sink_pkg::idx_t'(sink_pkg::NUM_NEIGHBORS - 1)) begin
                                state <= sink_pkg::S_DONE;
                            end else begin
                                i     <= i + 1'b1;
                                state <= sink_pkg::S_NEIGH;
                            end
                        end
                    end
                    // Last sink of the last neighbor compared without a hit.
                    sink_pkg::S_DONE: begin
                        state <= sink_pkg::S_IDLE;
                        done  <= 1'b1;
                    end
                    default: state <= sink_pkg::S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        rd_i <= i;
        rd_j <= j;
        if (state == sink_pkg::S_IDLE && ctrl.start) begin
            my_cluster <= ctrl.my_cluster;
        end
        if (rd_tag == sink_pkg::S_NEIGH) begin
            neigh_id <= mem_rdata;
        end
        if (rd_tag == sink_pkg::S_CLUSTER) begin
            neigh_cluster <= mem_rdata;
        end
    end

    always_comb begin
        status.busy      = (state != sink_pkg::S_IDLE);
        status.done      = done;
        status.found     = found;
        status.neigh_idx = match_i;
        status.sink_idx  = match_j;
    end

    a_rd_only_busy: assert property (@(posedge clock) disable iff (!rst_n)
        mem_rd.en |-> status.busy);
    a_done_not_busy: assert property (@(posedge clock) disable iff (!rst_n)
        !(status.done && status.busy));

endmodule

/* hw/axil_host_port.sv */
`timescale 1ns/1ps

module axil_host_port (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    awvalid,
    input  logic                    wvalid,
    input  logic                    bready,
    input  logic                    arvalid,
    input  logic                    rready,
    input  logic [11:0]             awaddr,
    input  logic [11:0]             araddr,
    input  logic [31:0]             wdata,
    output logic                    awready,
    output logic                    wready,
    output logic                    bvalid,
    output logic                    arready,
    output logic                    rvalid,
    output sink_pkg::axil_resp_e    bresp,
    output sink_pkg::axil_resp_e    rresp,
    output logic [31:0]             rdata,
    output sink_pkg::mem_wr_t       mem_wr,
    output sink_pkg::mem_rd_t       mem_rd,
    input  sink_pkg::word_t         mem_rdata,
    output sink_pkg::scan_ctrl_t    ctrl,
    input  sink_pkg::scan_status_t  status
);

    logic wr_hs, rd_hs, idle, lock;
    logic aw_mem, ar_mem, wr_err, ar_ok;
    logic start_q, rd_pend, rd_mem_q;
    logic [31:0] reg_rdata, rd_reg_q;
    sink_pkg::axil_resp_e rd_resp_q;
    sink_pkg::word_t my_cluster_q;

    assign wr_hs = awvalid && awready && wvalid && wready;
    assign rd_hs = arvalid && arready;

    // One transaction at a time. A new one waits until the last response is taken.
    assign idle = !(awready || arready || bvalid || rvalid || rd_pend);

    // A start that is still on its way to the scanner counts as busy.
    assign lock = status.busy || start_q;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------

    always_comb begin
        aw_mem = (awaddr[11:10] == 2'b00);
        wr_err = 1'b1;
        if (aw_mem) begin
            wr_err = lock;
        end else begin
            case (awaddr)
                sink_pkg::REG_CTRL:    wr_err = lock && wdata[0];
                sink_pkg::REG_CLUSTER: wr_err = 1'b0;
                default:               wr_err = 1'b1;
            endcase
        end
    end

    always_comb begin
        ar_mem    = (araddr[11:10] == 2'b00);
        ar_ok     = 1'b1;
        reg_rdata = '0;
        case (araddr)
            sink_pkg::REG_CTRL:    reg_rdata = '0;
            sink_pkg::REG_CLUSTER: reg_rdata = {16'h0000, my_cluster_q};
            sink_pkg::REG_STATUS:  reg_rdata = {29'd0, status.found, status.done, status.busy};
            sink_pkg::REG_MATCH:   reg_rdata = {20'd0, status.sink_idx, 2'b00, status.neigh_idx};
            default:               ar_ok = ar_mem;
        endcase
    end

    // Memory accesses go out in the handshake cycle itself.
    always_comb begin
        mem_wr.en   = wr_hs && aw_mem && !lock;
        mem_wr.addr = awaddr[9:2];
        mem_wr.data = wdata[15:0];
        mem_rd.en   = rd_hs && ar_mem;
        mem_rd.addr = araddr[9:2];
    end

    assign ctrl.start      = start_q;
    assign ctrl.my_cluster = my_cluster_q;

    // ----------------------------------------
    // Channel control
    // ----------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            awready      <= 1'b0;
            wready       <= 1'b0;
            bvalid       <= 1'b0;
            bresp        <= sink_pkg::OKAY;
            arready      <= 1'b0;
            rd_pend      <= 1'b0;
            rvalid       <= 1'b0;
            rresp        <= sink_pkg::OKAY;
            rdata        <= '0;
            start_q      <= 1'b0;
            my_cluster_q <= '0;
        end else begin
            start_q <= 1'b0;
            rd_pend <= rd_hs;

            // Writes win when both channels arrive together.
            if (idle && awvalid && wvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end else if (idle && arvalid) begin
                arready <= 1'b1;
            end

            if (wr_hs) begin
                awready <= 1'b0;
                wready  <= 1'b0;
                bvalid  <= 1'b1;
                bresp   <= wr_err ? sink_pkg::SLVERR : sink_pkg::OKAY;
                if (awaddr == sink_pkg::REG_CTRL && wdata[0] && !lock) begin
                    start_q <= 1'b1;
                end
                if (awaddr == sink_pkg::REG_CLUSTER) begin
                    my_cluster_q <= wdata[15:0];
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (rd_hs) begin
                arready <= 1'b0;
            end

            // Memory data is back one cycle after the handshake.
            if (rd_pend) begin
                rvalid <= 1'b1;
                rdata  <= rd_mem_q ? {16'h0000, mem_rdata} : rd_reg_q;
                rresp  <= rd_resp_q;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rd_hs) begin
            rd_mem_q  <= ar_mem;
            rd_reg_q  <= reg_rdata;
            rd_resp_q <= ar_ok ? sink_pkg::OKAY : sink_pkg::SLVERR;
        end
    end

    // A response may not be withdrawn before the master has taken it.
    a_bvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);
    a_rvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && !rready |=> rvalid);

endmodule

/* hw/node_table_mem.sv */
`timescale 1ns/1ps

module node_table_mem (
    input  logic                clock,
    input  logic                rst_n,
    input  sink_pkg::mem_wr_t   host_wr,
    input  sink_pkg::mem_rd_t   host_rd,
    output sink_pkg::word_t     host_rdata,
    input  sink_pkg::mem_rd_t   scan_rd,
    output sink_pkg::word_t     scan_rdata
);

    // Holds the sink table, the neighbor table and the cluster table.
    sink_pkg::word_t mem [sink_pkg::MEM_WORDS];

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    // Only the host writes. The scanner never modifies the tables.
    always_ff @(posedge clock) begin
        if (host_wr.en) begin
            mem[host_wr.addr] <= host_wr.data;
        end
    end

    // ----------------------------------------
    // Read ports
    // ----------------------------------------

    // Both ports sample the array before the write lands, so a read and a
    // write to the same word in one cycle return the old contents.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            host_rdata <= '0;
        end else if (host_rd.en) begin
            host_rdata <= mem[host_rd.addr];
        end
    end

    // The scanner port is independent of the host port and can read
    // on every cycle of a scan.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            scan_rdata <= '0;
        end else if (scan_rd.en) begin
            scan_rdata <= mem[scan_rd.addr];
        end
    end

endmodule

/* hw/sink_pkg.sv */
package sink_pkg;

    // ----------------------------------------
    // Node memory geometry
    // ----------------------------------------

    localparam int MEM_WORDS = 256;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  waddr_t;
    typedef logic [5:0]  idx_t;
    typedef logic [3:0]  sidx_t;

    // Word addresses where the three tables start.
    localparam waddr_t SINK_BASE    = 8'd4;
    localparam waddr_t NEIGH_BASE   = 8'd36;
    localparam waddr_t CLUSTER_BASE = 8'd100;

    localparam int NUM_SINKS     = 16;
    localparam int NUM_NEIGHBORS = 64;

    // ----------------------------------------
    // Host register map
    // ----------------------------------------

    // Byte addresses below 0x400 fall into the memory window.
    localparam logic [11:0] REG_CTRL    = 12'h400;
    localparam logic [11:0] REG_CLUSTER = 12'h404;
    localparam logic [11:0] REG_STATUS  = 12'h408;
    localparam logic [11:0] REG_MATCH   = 12'h40C;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_NEIGH,
        S_CLUSTER,
        S_SINKS,
        S_DONE
    } scan_state_e;

    // ----------------------------------------
    // Bundles between the blocks
    // ----------------------------------------

    typedef struct packed {
        logic  start;
        word_t my_cluster;
    } scan_ctrl_t;

    typedef struct packed {
        logic  busy;
        logic  done;
        logic  found;
        idx_t  neigh_idx;
        sidx_t sink_idx;
    } scan_status_t;

    typedef struct packed {
        logic   en;
        waddr_t addr;
    } mem_rd_t;

    typedef struct packed {
        logic   en;
        waddr_t addr;
        word_t  data;
    } mem_wr_t;

endpackage
